// File: project.f
+incdir+src
src/joybus_line_pkg.sv
src/joybus_proto_pkg.sv
src/joybus_rx_decoder.sv
src/joybus_cmd_parser.sv
src/joybus_data_crc.sv
src/joybus_responder.sv
src/joybus_tx_encoder.sv
src/fake_n64_controller.sv
verif/tb_fake_n64_controller.sv

// File: run.sh
#!/bin/sh
# build and run the joybus controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f project.f \
    --top-module tb_fake_n64_controller -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "simulation did not report success"
exit 1

// File: src/fake_n64_controller.sv
`timescale 1ns/1ps

module fake_n64_controller (
    input  logic        sample_clk,
    input  logic        reset,
    input  logic        data_rx,
    input  logic [15:0] buttons,
    input  logic [7:0]  stick_x,
    input  logic [7:0]  stick_y,
    output logic        data_tx
);
    logic bit_strobe;
    logic bit_value;
    logic frame_end;
    logic cmd_strobe;
    joybus_proto_pkg::cmd_t cmd;
    joybus_proto_pkg::pak_addr_t pak_addr;
    logic data_strobe;
    logic [7:0] data_byte;
    logic tx_start;
    logic [5:0] tx_len;
    logic [7:0] tx_byte;
    logic [5:0] tx_index;
    logic tx_busy;

    ////////////////////////////////////////////////////////////
    // host frame in
    joybus_rx_decoder i_rx_decoder (
        .sample_clk (sample_clk),
        .reset      (reset),
        .data_rx    (data_rx),
        .bit_strobe (bit_strobe),
        .bit_value  (bit_value),
        .frame_end  (frame_end)
    );

    joybus_cmd_parser i_cmd_parser (
        .sample_clk  (sample_clk),
        .reset       (reset),
        .bit_strobe  (bit_strobe),
        .bit_value   (bit_value),
        .frame_end   (frame_end),
        .cmd_strobe  (cmd_strobe),
        .cmd         (cmd),
        .pak_addr    (pak_addr),
        .data_strobe (data_strobe),
        .data_byte   (data_byte)
    );

    ////////////////////////////////////////////////////////////
    // reply out
    joybus_responder i_responder (
        .sample_clk  (sample_clk),
        .reset       (reset),
        .cmd_strobe  (cmd_strobe),
        .cmd         (cmd),
        .pak_addr    (pak_addr),
        .data_strobe (data_strobe),
        .data_byte   (data_byte),
        .buttons     (buttons),
        .stick_x     (stick_x),
        .stick_y     (stick_y),
        .tx_busy     (tx_busy),
        .tx_index    (tx_index),
        .tx_start    (tx_start),
        .tx_len      (tx_len),
        .tx_byte     (tx_byte)
    );

    joybus_tx_encoder i_tx_encoder (
        .sample_clk (sample_clk),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_len     (tx_len),
        .tx_byte    (tx_byte),
        .tx_index   (tx_index),
        .tx_busy    (tx_busy),
        .data_tx    (data_tx)
    );

endmodule

// File: src/joybus_cfg.svh
`ifndef JOYBUS_CFG_SVH
`define JOYBUS_CFG_SVH

// line timing, in sample clocks.
`define JB_QUARTER_CYCLES 4
`define JB_IDLE_CYCLES 48

// clocks between a prepared reply and its first pulse.
`define JB_REPLY_GAP 16

// 32-byte blocks of pak memory.
`define JB_PAK_BLOCKS 8

`endif

// File: src/joybus_cmd_parser.sv
`timescale 1ns/1ps

module joybus_cmd_parser (
    input  logic                        sample_clk,
    input  logic                        reset,
    input  logic                        bit_strobe,
    input  logic                        bit_value,
    input  logic                        frame_end,
    output logic                        cmd_strobe,
    output joybus_proto_pkg::cmd_t      cmd,
    output joybus_proto_pkg::pak_addr_t pak_addr,
    output logic                        data_strobe,
    output logic [7:0]                  data_byte
);
    logic [8:0]  bit_cnt; // up to 35 bytes plus stop.
    logic [7:0]  shift;
    logic [7:0]  new_byte;
    logic [7:0]  cmd_byte;
    logic [15:0] addr_word;
    logic [7:0]  data_buf [32];
    logic [5:0]  byte_idx;
    logic [8:0]  want_bits;
    logic        cmd_known;
    joybus_proto_pkg::cmd_t cmd_kind;
    logic        streaming;
    logic [4:0]  stream_idx;

    assign new_byte = {shift[6:0], bit_value};
    assign byte_idx = bit_cnt[8:3];

    // frame length each command byte needs, stop bit included.
    always_comb begin
        cmd_known = 1'b1;
        cmd_kind  = joybus_proto_pkg::CMD_INFO;
        want_bits = 9'd9;
        case (cmd_byte)
            8'h00, 8'hff: cmd_kind = joybus_proto_pkg::CMD_INFO;
            8'h01: cmd_kind = joybus_proto_pkg::CMD_STATUS;
            8'h02: begin
                cmd_kind  = joybus_proto_pkg::CMD_READ;
                want_bits = 9'd25;
            end
            8'h03: begin
                cmd_kind  = joybus_proto_pkg::CMD_WRITE;
                want_bits = 9'd281;
            end
            default: cmd_known = 1'b0;
        endcase
    end

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            cmd_strobe  <= 1'b0;
            cmd         <= joybus_proto_pkg::CMD_INFO;
            pak_addr    <= '0;
            streaming   <= 1'b0;
            stream_idx  <= '0;
            data_strobe <= 1'b0;
        end else begin
            cmd_strobe  <= 1'b0;
            data_strobe <= 1'b0;
            if (bit_strobe && bit_cnt != '1) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (frame_end) begin
                bit_cnt <= '0;
                if (cmd_known && bit_cnt == want_bits) begin
                    cmd_strobe   <= 1'b1;
                    cmd          <= cmd_kind;
                    pak_addr.raw <= addr_word;
                    streaming    <= (cmd_kind == joybus_proto_pkg::CMD_WRITE);
                    stream_idx   <= '0;
                end
            end
            if (streaming) begin
                data_strobe <= 1'b1;
                stream_idx  <= stream_idx + 1'b1;
                if (stream_idx == 5'd31) begin
                    streaming <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (bit_strobe) begin
            shift <= new_byte;
            if (bit_cnt[2:0] == 3'd7) begin
                if (byte_idx == 6'd0) begin
                    cmd_byte <= new_byte;
                end else if (byte_idx < 6'd3) begin
                    addr_word <= {addr_word[7:0], new_byte}; // high byte first.
                end else if (byte_idx < 6'd35) begin
                    data_buf[5'(byte_idx - 6'd3)] <= new_byte;
                end
            end
        end
        data_byte <= data_buf[stream_idx];
    end

    // write data starts right behind its command.
    assert property (@(posedge sample_clk) disable iff (reset)
        $rose(data_strobe) |-> $past(cmd_strobe) && cmd == joybus_proto_pkg::CMD_WRITE);

endmodule

// File: src/joybus_data_crc.sv
`timescale 1ns/1ps

module joybus_data_crc (
    input  logic       sample_clk,
    input  logic       reset,
    input  logic       crc_clear,
    input  logic       crc_strobe,
    input  logic [7:0] crc_byte,
    output logic [7:0] crc_value
);
    logic [7:0] crc_next;

    // one byte, msb first, eight shift steps.
    always_comb begin
        crc_next = crc_value ^ crc_byte;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) begin
                crc_next = {crc_next[6:0], 1'b0} ^ joybus_proto_pkg::CRC_POLY;
            end else begin
                crc_next = {crc_next[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (reset || crc_clear) begin
            crc_value <= '0;
        end else if (crc_strobe) begin
            crc_value <= crc_next;
        end
    end

endmodule

// File: src/joybus_line_pkg.sv
package joybus_line_pkg;

    // where a bit cell stands on the line.
    typedef enum logic [1:0] {
        IDLE = 2'd0, // line released.
        LOW  = 2'd1,
        HIGH = 2'd2,
        STOP = 2'd3  // closing pulse of a frame.
    } cell_phase_t;

endpackage

// File: src/joybus_proto_pkg.sv
package joybus_proto_pkg;

    typedef enum logic [1:0] {
        CMD_INFO   = 2'd0, // also serves RESET.
        CMD_STATUS = 2'd1,
        CMD_READ   = 2'd2,
        CMD_WRITE  = 2'd3
    } cmd_t;

    // pak address word, taken whole or as block number plus crc.
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [10:0] offset; // block number.
            logic [4:0]  crc;
        } fields;
    } pak_addr_t;

    localparam logic [7:0] INFO_ID0 = 8'h05;
    localparam logic [7:0] INFO_ID1 = 8'h00;
    localparam logic [7:0] INFO_ID2 = 8'h01; // pak present.

    localparam logic [7:0] CRC_POLY = 8'h85;
    localparam int MAX_REPLY = 33; // read data plus crc.

endpackage

// File: src/joybus_responder.sv
`timescale 1ns/1ps
`include "joybus_cfg.svh"

module joybus_responder (
    input  logic                        sample_clk,
    input  logic                        reset,
    input  logic                        cmd_strobe,
    input  joybus_proto_pkg::cmd_t      cmd,
    input  joybus_proto_pkg::pak_addr_t pak_addr,
    input  logic                        data_strobe,
    input  logic [7:0]                  data_byte,
    input  logic [15:0]                 buttons,
    input  logic [7:0]                  stick_x,
    input  logic [7:0]                  stick_y,
    input  logic                        tx_busy,
    input  logic [5:0]                  tx_index,
    output logic                        tx_start,
    output logic [5:0]                  tx_len,
    output logic [7:0]                  tx_byte
);
    localparam int BW = $clog2(`JB_PAK_BLOCKS);
    localparam int GW = $clog2(`JB_REPLY_GAP + 1);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_PREP = 2'd1; // 32 bytes through the crc.
    localparam logic [1:0] ST_GAP  = 2'd2;

    logic [1:0]    state;
    joybus_proto_pkg::cmd_t cmd_r;
    logic [BW-1:0] block_r;
    logic [4:0]    prep_cnt;
    logic [GW-1:0] gap_cnt;
    logic          accept;
    logic          crc_strobe;
    logic [7:0]    crc_byte;
    logic [7:0]    crc_value;
    logic [7:0]    mem_rd;
    logic [7:0]    pak_mem [`JB_PAK_BLOCKS * 32];
    logic [7:0]    reply_buf [joybus_proto_pkg::MAX_REPLY];

    assign accept     = cmd_strobe && state == ST_IDLE && !tx_busy && !tx_start;
    assign mem_rd     = pak_mem[{block_r, prep_cnt}];
    assign crc_strobe = (state == ST_PREP) &&
                        (cmd_r == joybus_proto_pkg::CMD_READ || data_strobe);
    assign crc_byte   = (cmd_r == joybus_proto_pkg::CMD_WRITE) ? data_byte : mem_rd;
    assign tx_byte    = reply_buf[tx_index]; // encoder sets the pace.

    joybus_data_crc i_data_crc (
        .sample_clk (sample_clk),
        .reset      (reset),
        .crc_clear  (accept),
        .crc_strobe (crc_strobe),
        .crc_byte   (crc_byte),
        .crc_value  (crc_value)
    );

    ////////////////////////////////////////////////////////////
    // reply sequencing
    always_ff @(posedge sample_clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            cmd_r    <= joybus_proto_pkg::CMD_INFO;
            block_r  <= '0;
            prep_cnt <= '0;
            gap_cnt  <= '0;
            tx_start <= 1'b0;
            tx_len   <= '0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        cmd_r    <= cmd;
                        block_r  <= BW'(pak_addr.fields.offset % `JB_PAK_BLOCKS);
                        prep_cnt <= '0;
                        gap_cnt  <= '0;
                        case (cmd)
                            joybus_proto_pkg::CMD_INFO:   tx_len <= 6'd3;
                            joybus_proto_pkg::CMD_STATUS: tx_len <= 6'd4;
                            joybus_proto_pkg::CMD_READ:   tx_len <= 6'(joybus_proto_pkg::MAX_REPLY);
                            default:                      tx_len <= 6'd1; // crc only.
                        endcase
                        if (cmd == joybus_proto_pkg::CMD_READ ||
                            cmd == joybus_proto_pkg::CMD_WRITE) begin
                            state <= ST_PREP;
                        end else begin
                            state <= ST_GAP;
                        end
                    end
                end
                ST_PREP: begin
                    prep_cnt <= prep_cnt + 1'b1;
                    if (prep_cnt == 5'd31) begin
                        state <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GW'(`JB_REPLY_GAP - 1)) begin
                        tx_start <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // pak memory and reply buffer
    always_ff @(posedge sample_clk) begin
        if (accept && cmd == joybus_proto_pkg::CMD_INFO) begin
            reply_buf[0] <= joybus_proto_pkg::INFO_ID0;
            reply_buf[1] <= joybus_proto_pkg::INFO_ID1;
            reply_buf[2] <= joybus_proto_pkg::INFO_ID2;
        end
        if (accept && cmd == joybus_proto_pkg::CMD_STATUS) begin
            reply_buf[0] <= buttons[15:8];
            reply_buf[1] <= buttons[7:0];
            reply_buf[2] <= stick_x;
            reply_buf[3] <= stick_y;
        end
        if (state == ST_PREP) begin
            if (cmd_r == joybus_proto_pkg::CMD_READ) begin
                reply_buf[prep_cnt] <= mem_rd;
            end else if (data_strobe) begin
                pak_mem[{block_r, prep_cnt}] <= data_byte;
            end
        end
        // crc is final one cycle after the last byte.
        if (state == ST_GAP && gap_cnt == '0) begin
            if (cmd_r == joybus_proto_pkg::CMD_READ) begin
                reply_buf[joybus_proto_pkg::MAX_REPLY - 1] <= crc_value;
            end else if (cmd_r == joybus_proto_pkg::CMD_WRITE) begin
                reply_buf[0] <= crc_value;
            end
        end
    end

    // no reply starts while the previous one is on the line.
    assert property (@(posedge sample_clk) disable iff (reset) tx_start |-> !tx_busy);

endmodule

// File: src/joybus_rx_decoder.sv
`timescale 1ns/1ps
`include "joybus_cfg.svh"

module joybus_rx_decoder (
    input  logic sample_clk,
    input  logic reset,
    input  logic data_rx,
    output logic bit_strobe,
    output logic bit_value,
    output logic frame_end
);
    localparam int CW = $clog2(`JB_IDLE_CYCLES + 1);

    logic rx_meta;
    logic rx_sync;
    logic [CW-1:0] cnt; // low time, then high time.
    joybus_line_pkg::cell_phase_t rx_phase;

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            rx_phase   <= joybus_line_pkg::IDLE;
            cnt        <= '0;
            bit_strobe <= 1'b0;
            bit_value  <= 1'b0;
            frame_end  <= 1'b0;
        end else begin
            rx_meta    <= data_rx;
            rx_sync    <= rx_meta;
            bit_strobe <= 1'b0;
            frame_end  <= 1'b0;
            if (!rx_sync) begin
                if (rx_phase != joybus_line_pkg::LOW) begin
                    rx_phase <= joybus_line_pkg::LOW;
                    cnt      <= CW'(1);
                end else if (cnt != '1) begin
                    cnt <= cnt + 1'b1; // saturates on a stuck line.
                end
            end else if (rx_phase == joybus_line_pkg::LOW) begin
                // rising edge closes the low pulse.
                bit_strobe <= 1'b1;
                bit_value  <= (cnt < CW'(2 * `JB_QUARTER_CYCLES));
                rx_phase   <= joybus_line_pkg::HIGH;
                cnt        <= CW'(1);
            end else if (rx_phase == joybus_line_pkg::HIGH) begin
                if (cnt == CW'(`JB_IDLE_CYCLES - 1)) begin
                    frame_end <= 1'b1;
                    rx_phase  <= joybus_line_pkg::IDLE;
                end
                cnt <= cnt + 1'b1;
            end
        end
    end

    // a frame closes only after a released line, never on a bit.
    assert property (@(posedge sample_clk) disable iff (reset)
        frame_end |-> !bit_strobe && $past(rx_phase) == joybus_line_pkg::HIGH);

endmodule

// File: src/joybus_tx_encoder.sv
`timescale 1ns/1ps
`include "joybus_cfg.svh"

module joybus_tx_encoder (
    input  logic       sample_clk,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [5:0] tx_len,
    input  logic [7:0] tx_byte,
    output logic [5:0] tx_index,
    output logic       tx_busy,
    output logic       data_tx
);
    localparam int Q  = `JB_QUARTER_CYCLES;
    localparam int CW = $clog2(4 * Q);
    localparam logic [CW-1:0] CELL_LAST = CW'(4 * Q - 1);

    joybus_line_pkg::cell_phase_t phase;
    logic [CW-1:0] cnt; // position inside the cell.
    logic [2:0]    bit_idx;
    logic [5:0]    len_r;
    logic [CW-1:0] low_last;

    // a 1 is a short low, a 0 a long one.
    assign low_last  = tx_byte[bit_idx] ? CW'(Q - 1) : CW'(3 * Q - 1);
    assign tx_busy   = (phase != joybus_line_pkg::IDLE);

    always_ff @(posedge sample_clk) begin
        if (reset) begin
            phase    <= joybus_line_pkg::IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            tx_index <= '0;
            len_r    <= '0;
            data_tx  <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
            case (phase)
                joybus_line_pkg::IDLE: begin
                    cnt <= '0;
                    if (tx_start) begin
                        phase    <= joybus_line_pkg::LOW;
                        len_r    <= tx_len;
                        tx_index <= '0;
                        bit_idx  <= 3'd7; // msb first.
                        data_tx  <= 1'b0;
                    end
                end
                joybus_line_pkg::LOW: begin
                    if (cnt == low_last) begin
                        phase   <= joybus_line_pkg::HIGH;
                        data_tx <= 1'b1;
                    end
                end
                joybus_line_pkg::HIGH: begin
                    if (cnt == CELL_LAST) begin
                        data_tx <= 1'b0;
                        bit_idx <= bit_idx - 1'b1;
                        if (bit_idx != 3'd0) begin
                            phase <= joybus_line_pkg::LOW;
                        end else if (tx_index != len_r - 1'b1) begin
                            tx_index <= tx_index + 1'b1;
                            phase    <= joybus_line_pkg::LOW;
                        end else begin
                            phase <= joybus_line_pkg::STOP;
                        end
                    end
                end
                default: begin
                    // two quarters low, then released to the end of the cell.
                    if (cnt == CW'(2 * Q - 1)) begin
                        data_tx <= 1'b1;
                    end
                    if (cnt == CELL_LAST) begin
                        phase <= joybus_line_pkg::IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: verif/tb_fake_n64_controller.sv
`timescale 1ns/1ps
`include "joybus_cfg.svh"

module tb_fake_n64_controller;
    typedef logic [7:0] byte_q_t [$];

    localparam int Q = `JB_QUARTER_CYCLES;
    localparam int SILENT_CYCLES = 3000;
    localparam int REPLY_WAIT = 35 * 32 * Q + 500; // longest reply plus latency.
    // 13 frames, 124 host bytes and 148 reply bytes.
    localparam int TIMEOUT_CYCLES = (124 + 148) * 32 * Q + 13 * 256
                                    + 2 * SILENT_CYCLES + 1000;

    logic        sample_clk;
    logic        reset;
    logic        data_rx;
    logic [15:0] buttons;
    logic [7:0]  stick_x;
    logic [7:0]  stick_y;
    logic        data_tx;

    logic [31:0] lfsr_state;
    logic [7:0]  shadow_mem [`JB_PAK_BLOCKS * 32];
    byte_q_t     exp_q;
    byte_q_t     got_q;
    logic        exp_valid;
    int          replies_checked;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    event        reply_ready;

    fake_n64_controller i_fake_n64_controller (
        .sample_clk (sample_clk),
        .reset      (reset),
        .data_rx    (data_rx),
        .buttons    (buttons),
        .stick_x    (stick_x),
        .stick_y    (stick_y),
        .data_tx    (data_tx)
    );

    initial begin
        sample_clk = 1'b0;
        forever #4 sample_clk = ~sample_clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers

    // taps of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic byte_q_t cmd_frame(input logic [7:0] c, input logic [15:0] addr,
                                          input int addr_bytes);
        byte_q_t f;
        f.push_back(c);
        if (addr_bytes > 0) f.push_back(addr[15:8]);
        if (addr_bytes > 1) f.push_back(addr[7:0]);
        return f;
    endfunction

    function automatic byte_q_t write_frame(input logic [15:0] addr);
        byte_q_t f;
        f = cmd_frame(8'h03, addr, 2);
        for (int i = 0; i < 32; i++) begin
            f.push_back(8'(random_bits(8)));
        end
        return f;
    endfunction

    task automatic drive_line(input logic level, input int cycles);
        data_rx = level;
        repeat (cycles) @(negedge sample_clk);
    endtask

    task automatic send_bit(input logic value);
        if (value) begin
            drive_line(1'b0, Q);
            drive_line(1'b1, 3 * Q);
        end else begin
            drive_line(1'b0, 3 * Q);
            drive_line(1'b1, Q);
        end
    endtask

    task automatic send_frame(input byte_q_t frame);
        foreach (frame[i]) begin
            for (int b = 7; b >= 0; b--) begin
                send_bit(frame[i][b]);
            end
        end
        drive_line(1'b0, Q); // host stop pulse.
        drive_line(1'b1, Q);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [7:0] crc8(input byte_q_t data);
        logic [7:0] crc;
        logic       fb;
        crc = 8'h00;
        foreach (data[i]) begin
            for (int b = 7; b >= 0; b--) begin
                fb = crc[7] ^ data[i][b];
                crc = {crc[6:0], 1'b0};
                if (fb) crc = crc ^ 8'h85;
            end
        end
        return crc;
    endfunction

    function automatic int pak_block(input logic [15:0] addr);
        return int'(addr[15:5]) % `JB_PAK_BLOCKS;
    endfunction

    // empty result means the frame must be dropped.
    function automatic byte_q_t expected_reply(input byte_q_t frame);
        byte_q_t r;
        byte_q_t data;
        int      blk;
        case (frame[0])
            8'h00, 8'hff: begin
                if (frame.size() == 1) begin
                    r.push_back(8'h05);
                    r.push_back(8'h00);
                    r.push_back(8'h01);
                end
            end
            8'h01: begin
                if (frame.size() == 1) begin
                    r.push_back(buttons[15:8]);
                    r.push_back(buttons[7:0]);
                    r.push_back(stick_x);
                    r.push_back(stick_y);
                end
            end
            8'h02: begin
                if (frame.size() == 3) begin
                    blk = pak_block({frame[1], frame[2]});
                    for (int i = 0; i < 32; i++) r.push_back(shadow_mem[blk * 32 + i]);
                    r.push_back(crc8(r));
                end
            end
            8'h03: begin
                if (frame.size() == 35) begin
                    for (int i = 3; i < 35; i++) data.push_back(frame[i]);
                    r.push_back(crc8(data));
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic update_shadow(input byte_q_t frame);
        int blk;
        if (frame[0] == 8'h03 && frame.size() == 35) begin
            blk = pak_block({frame[1], frame[2]});
            for (int i = 0; i < 32; i++) shadow_mem[blk * 32 + i] = frame[i + 3];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reply decoding and comparison

    initial begin : decode_reply
        int         low_len;
        int         bit_cnt;
        logic [7:0] shreg;
        low_len = 0;
        bit_cnt = 0;
        shreg   = '0;
        forever begin
            @(negedge sample_clk);
            if (data_tx === 1'b0) begin
                low_len++;
            end else if (low_len != 0) begin
                if (low_len * 2 < 3 * Q || low_len * 2 >= 5 * Q) begin
                    shreg = {shreg[6:0], (low_len * 2 < 3 * Q)};
                    bit_cnt++;
                    if (bit_cnt == 8) begin
                        got_q.push_back(shreg);
                        bit_cnt = 0;
                    end
                end else begin
                    // long stop pulse closes the reply.
                    assert (bit_cnt == 0) else begin
                        $display("reply ended in the middle of a byte");
                        errors++;
                    end
                    bit_cnt = 0;
                    -> reply_ready;
                end
                low_len = 0;
            end
        end
    end

    initial begin : compare_reply
        forever begin
            @(reply_ready);
            assert (exp_valid) else begin
                $display("unexpected reply of %0d bytes", got_q.size());
                errors++;
            end
            if (exp_valid) begin
                assert (got_q.size() == exp_q.size()) else begin
                    $display("Fail reply_len got %h expected %h", got_q.size(), exp_q.size());
                    errors++;
                end
                for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
                    assert (got_q[i] === exp_q[i]) else begin
                        $display("Fail tx_byte[%0d] got %h expected %h", i, got_q[i], exp_q[i]);
                        errors++;
                    end
                end
            end
            got_q.delete();
            replies_checked++;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence

    task automatic run_frame(input byte_q_t frame, input string name);
        int seen;
        int waited;
        exp_q = expected_reply(frame);
        update_shadow(frame);
        exp_valid = (exp_q.size() != 0);
        seen = replies_checked;
        send_frame(frame);
        if (exp_valid) begin
            waited = 0;
            while (replies_checked == seen && waited < REPLY_WAIT) begin
                @(negedge sample_clk);
                waited++;
            end
            assert (replies_checked != seen) else begin
                $display("no reply to %s within %0d cycles", name, REPLY_WAIT);
                errors++;
            end
        end else begin
            repeat (SILENT_CYCLES) @(negedge sample_clk);
        end
        exp_valid = 1'b0;
        repeat (32) @(negedge sample_clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin : run_tests
        logic [15:0] addr_a;
        logic [15:0] addr_b;
        logic [15:0] addr_c;
        logic        idle_ok;
        data_rx         = 1'b1;
        reset           = 1'b1;
        buttons         = '0;
        stick_x         = '0;
        stick_y         = '0;
        lfsr_state      = 32'h68afedfe;
        exp_valid       = 1'b0;
        replies_checked = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        repeat (5) @(negedge sample_clk);
        reset = 1'b0;

        idle_ok = 1'b1;
        repeat (100) begin
            @(negedge sample_clk);
            if (data_tx !== 1'b1) idle_ok = 1'b0;
        end
        assert (idle_ok) else begin
            $display("data_tx moved with no host activity");
            errors++;
        end
        run_frame(cmd_frame(8'h00, 16'h0000, 0), "INFO");
        run_frame(cmd_frame(8'hff, 16'h0000, 0), "RESET");
        finish_test("idle line, INFO and RESET");

        buttons = 16'(random_bits(16));
        stick_x = 8'(random_bits(8));
        stick_y = 8'(random_bits(8));
        run_frame(cmd_frame(8'h01, 16'h0000, 0), "STATUS");
        finish_test("STATUS");

        addr_a = 16'(random_bits(16));
        run_frame(write_frame(addr_a), "WRITE");
        run_frame(cmd_frame(8'h02, addr_a, 2), "READ");
        finish_test("WRITE then READ");

        addr_b = 16'(random_bits(16));
        addr_c = {addr_b[15:5] + 11'd3, 5'(random_bits(5))}; // other block mod 8.
        run_frame(write_frame(addr_b), "WRITE b");
        run_frame(write_frame(addr_c), "WRITE c");
        run_frame(cmd_frame(8'h02, addr_b, 2), "READ b");
        run_frame(cmd_frame(8'h02, addr_c, 2), "READ c");
        run_frame(cmd_frame(8'h02, addr_c ^ 16'h001f, 2), "READ c with other crc");
        finish_test("two blocks and address crc field");

        run_frame(cmd_frame(8'h10, 16'h0000, 0), "unknown command");
        run_frame(cmd_frame(8'h02, addr_a, 1), "truncated READ");
        run_frame(cmd_frame(8'h00, 16'h0000, 0), "INFO after drops");
        finish_test("dropped frames");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : timeout_guard
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge sample_clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
